/* common/ssd_pkg.sv */
// Shared types and constants for the seven-segment timer.
// Timer range is 0:00 to 7:59, so minutes fit in 3 bits.
// Display command bytes follow the serial 7-segment display command set.
// Segment bit 0 is segment a, bit 6 is segment g, bit 7 stays 0.
`default_nettype none

package ssd_pkg;

    // Current or loaded timer value, minutes:tens:seconds
    typedef struct packed {
        logic [2:0] min;      // 0 to 7
        logic [2:0] sec_ten;  // 0 to 5
        logic [3:0] sec_one;  // 0 to 9
    } timer_value_t;

    typedef enum logic {
        dir_up   = 1'b0,
        dir_down = 1'b1
    } count_dir_t;

    // Byte addresses on the 8-bit APB paddr
    typedef enum logic [7:0] {
        addr_ctrl   = 8'h00,
        addr_load   = 8'h04,
        addr_value  = 8'h08,
        addr_status = 8'h0C
    } reg_addr_t;

    // Seven-segment bitmap, gfedcba in bits 6:0
    typedef logic [7:0] seg_t;

    // Setup sequence
    localparam logic [7:0] cmd_reset   = 8'h76;  // Clear display
    localparam logic [7:0] cmd_decimal = 8'h77;  // Decimal point control
    localparam logic [7:0] dp_colon    = 8'h10;  // Colon on, all points off

    // Digit position commands, one per refreshed digit
    localparam logic [7:0] cmd_digit2 = 8'h7C;  // Minutes
    localparam logic [7:0] cmd_digit3 = 8'h7D;  // Tens of seconds
    localparam logic [7:0] cmd_digit4 = 8'h7E;  // Seconds

endpackage

`default_nettype wire

/* design/apb_timer_regs.sv */
// APB slave for the timer. No wait states and no error responses.
// Clear and load are one-cycle pulses issued on the write edge.
// Done is sticky; any write to the control register clears it.
// Read data is a combinational mux, valid in the access phase.
`timescale 1ns/1ps
`default_nettype none

module apb_timer_regs (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [7:0]           paddr,
    input  logic [31:0]          pwdata,
    output logic [31:0]          prdata,
    output logic                 pready,
    output logic                 pslverr,
    input  ssd_pkg::timer_value_t value,
    input  logic                 reach_zero,
    output logic                 run,
    output ssd_pkg::count_dir_t  dir,
    output logic                 disp_enable,
    output logic                 load,
    output ssd_pkg::timer_value_t load_value,
    output logic                 clear
);
    ssd_pkg::reg_addr_t addr;
    logic wr_en;
    logic done;

    assign addr    = ssd_pkg::reg_addr_t'(paddr);
    assign wr_en   = psel && penable && pwrite;  // Access phase write
    assign pready  = 1'b1;
    assign pslverr = 1'b0;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            run         <= 1'b0;
            dir         <= ssd_pkg::dir_up;
            disp_enable <= 1'b0;
            load        <= 1'b0;
            clear       <= 1'b0;
            done        <= 1'b0;
        end else begin
            load  <= 1'b0;
            clear <= 1'b0;
            if (wr_en && addr == ssd_pkg::addr_ctrl) begin
                run         <= pwdata[0];
                dir         <= ssd_pkg::count_dir_t'(pwdata[1]);
                disp_enable <= pwdata[2];
                clear       <= pwdata[3];  // Self-clearing
            end
            if (wr_en && addr == ssd_pkg::addr_load) begin
                load <= 1'b1;
            end
            if (reach_zero) begin
                done <= 1'b1;  // Set wins over a clearing write
            end else if (wr_en && addr == ssd_pkg::addr_ctrl) begin
                done <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && addr == ssd_pkg::addr_load) begin
            load_value <= ssd_pkg::timer_value_t'(pwdata[9:0]);
        end
    end

    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            case (addr)
                ssd_pkg::addr_ctrl:   prdata[2:0] = {disp_enable, dir, run};  // Clear reads 0
                ssd_pkg::addr_value:  prdata[9:0] = value;
                ssd_pkg::addr_status: prdata[0]   = done;
                default:              prdata      = '0;  // Load is write-only
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/timer_counter.sv */
// One-second prescaler and minutes:seconds up/down counter.
// tick_div is clocks per second and must be 2 or more.
// Up count wraps 7:59 to 0:00. Down count stops at 0:00.
// Load wins over a tick in the same cycle; clear wins over both.
`timescale 1ns/1ps
`default_nettype none

module timer_counter #(
    parameter logic [15:0] tick_div = 16'd1000
) (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  run,
    input  ssd_pkg::count_dir_t   dir,
    input  logic                  load,
    input  ssd_pkg::timer_value_t load_value,
    input  logic                  clear,
    output ssd_pkg::timer_value_t value,
    output logic                  reach_zero
);
    logic [15:0] pre_cnt;
    logic count_en;
    logic tick;
    ssd_pkg::timer_value_t next_val;

    // Prescaler parks once a down count sits at zero
    assign count_en = run && !(dir == ssd_pkg::dir_down && value == '0);
    assign tick     = count_en && (pre_cnt == tick_div - 16'd1);

    always_comb begin
        next_val = value;
        if (dir == ssd_pkg::dir_up) begin
            if (value.sec_one < 4'd9) begin
                next_val.sec_one = value.sec_one + 4'd1;
            end else begin
                next_val.sec_one = 4'd0;
                if (value.sec_ten < 3'd5) begin
                    next_val.sec_ten = value.sec_ten + 3'd1;
                end else begin
                    next_val.sec_ten = 3'd0;
                    next_val.min     = value.min + 3'd1;  // 7 wraps to 0
                end
            end
        end else if (value != '0) begin
            if (value.sec_one != 4'd0) begin
                next_val.sec_one = value.sec_one - 4'd1;
            end else begin
                next_val.sec_one = 4'd9;
                if (value.sec_ten != 3'd0) begin
                    next_val.sec_ten = value.sec_ten - 3'd1;
                end else begin
                    next_val.sec_ten = 3'd5;
                    next_val.min     = value.min - 3'd1;
                end
            end
        end
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            pre_cnt    <= '0;
            value      <= '0;
            reach_zero <= 1'b0;
        end else begin
            reach_zero <= 1'b0;
            if (clear) begin
                pre_cnt <= '0;
                value   <= '0;
            end else begin
                if (count_en) begin
                    pre_cnt <= tick ? 16'd0 : pre_cnt + 16'd1;
                end
                if (load) begin
                    value <= load_value;
                end else if (tick) begin
                    value      <= next_val;
                    reach_zero <= (dir == ssd_pkg::dir_down) && (next_val == '0);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/ssd_digit_encoder.sv */
// Decimal digit to seven-segment bitmap, purely combinational.
// Values above 9 blank the digit.
`timescale 1ns/1ps
`default_nettype none

module ssd_digit_encoder (
    input  logic [3:0]    digit,
    output ssd_pkg::seg_t seg
);

    // Active-high segments, gfedcba
    always_comb begin
        case (digit)
            4'd0:    seg = 8'h3F;
            4'd1:    seg = 8'h06;
            4'd2:    seg = 8'h5B;
            4'd3:    seg = 8'h4F;
            4'd4:    seg = 8'h66;
            4'd5:    seg = 8'h6D;
            4'd6:    seg = 8'h7D;
            4'd7:    seg = 8'h07;
            4'd8:    seg = 8'h7F;
            4'd9:    seg = 8'h6F;
            default: seg = 8'h00;  // Blank
        endcase
    end

endmodule

`default_nettype wire

/* spi/spi_clock_divider.sv */
// SCK edge enable generator. sck_half is clocks per half period, 1 or more.
// Held at zero while sck_clear is high; the first pulse afterwards is a rise.
`timescale 1ns/1ps
`default_nettype none

module spi_clock_divider #(
    parameter logic [7:0] sck_half = 8'd4
) (
    input  logic clk,
    input  logic nrst,
    input  logic sck_clear,
    output logic sck_rise,
    output logic sck_fall
);
    logic [7:0] half_cnt;
    logic phase;  // 0 means next edge is a rise

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            half_cnt <= '0;
            phase    <= 1'b0;
            sck_rise <= 1'b0;
            sck_fall <= 1'b0;
        end else if (sck_clear) begin
            half_cnt <= '0;
            phase    <= 1'b0;
            sck_rise <= 1'b0;
            sck_fall <= 1'b0;
        end else begin
            sck_rise <= 1'b0;
            sck_fall <= 1'b0;
            if (half_cnt == sck_half - 8'd1) begin
                half_cnt <= '0;
                phase    <= ~phase;
                sck_rise <= ~phase;
                sck_fall <= phase;
            end else begin
                half_cnt <= half_cnt + 8'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* spi/ssd_spi_master.sv */
// SPI mode 0 master for the serial seven-segment display with MOSI only.
// Sends reset and colon setup once, then refreshes three digits forever.
// Bitmaps are latched at the start of every refresh loop.
// Dropping enable returns to idle in one cycle and clears the divider.
`timescale 1ns/1ps
`default_nettype none

module ssd_spi_master (
    input  logic                clk,
    input  logic                nrst,
    input  logic                enable,
    input  ssd_pkg::seg_t [2:0] digits,  // 0 min, 1 tens, 2 seconds
    input  logic                sck_rise,
    input  logic                sck_fall,
    output logic                sck_clear,
    output logic                ss,
    output logic                sck,
    output logic                sdi
);
    typedef enum logic [4:0] {
        idle       = 5'd0,
        load_1     = 5'd1,
        sent_rst_1 = 5'd2,
        wait_rst_1 = 5'd3,
        sent_cln_1 = 5'd4,
        wait_cln_1 = 5'd5,
        sent_cln_2 = 5'd6,
        wait_cln_2 = 5'd7,
        sent_cmd_2 = 5'd8,
        wait_cmd_2 = 5'd9,
        sent_dig_2 = 5'd10,
        wait_dig_2 = 5'd11,
        sent_cmd_3 = 5'd12,
        wait_cmd_3 = 5'd13,
        sent_dig_3 = 5'd14,
        wait_dig_3 = 5'd15,
        sent_cmd_4 = 5'd16,
        wait_cmd_4 = 5'd17,
        sent_dig_4 = 5'd18,
        wait_dig_4 = 5'd19,
        load_2     = 5'd20
    } state_t;

    state_t state, nxt_state;
    logic [3:0] sck_sent, nxt_sck_sent;  // Bits sent, then falls waited
    logic [47:0] shift_reg, nxt_shift_reg;
    logic [47:0] frame_data;
    logic [7:0] setup_byte;
    logic is_setup;
    logic tx_bit;
    logic nxt_ss, nxt_sck, nxt_sdi;

    assign frame_data = {ssd_pkg::cmd_digit2, digits[0],
                         ssd_pkg::cmd_digit3, digits[1],
                         ssd_pkg::cmd_digit4, digits[2]};

    assign is_setup = (state == sent_rst_1) || (state == sent_cln_1) || (state == sent_cln_2);

    always_comb begin
        case (state)
            sent_rst_1: setup_byte = ssd_pkg::cmd_reset;
            sent_cln_1: setup_byte = ssd_pkg::cmd_decimal;
            default:    setup_byte = ssd_pkg::dp_colon;
        endcase
    end

    // MSB first
    assign tx_bit = is_setup ? setup_byte[3'd7 - sck_sent[2:0]] : shift_reg[47];

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            state    <= idle;
            sck_sent <= '0;
            ss       <= 1'b1;
            sck      <= 1'b0;
            sdi      <= 1'b0;
        end else begin
            state    <= nxt_state;
            sck_sent <= nxt_sck_sent;
            ss       <= nxt_ss;
            sck      <= nxt_sck;
            sdi      <= nxt_sdi;
        end
    end

    always_ff @(posedge clk) begin
        shift_reg <= nxt_shift_reg;
    end

    always_comb begin
        nxt_state     = state;
        nxt_sck_sent  = sck_sent;
        nxt_shift_reg = shift_reg;
        nxt_ss        = ss;
        nxt_sck       = sck;
        nxt_sdi       = sdi;
        sck_clear     = 1'b0;
        if (!enable) begin
            nxt_state    = idle;
            nxt_sck_sent = '0;
            nxt_ss       = 1'b1;
            nxt_sck      = 1'b0;
            nxt_sdi      = 1'b0;
            sck_clear    = 1'b1;
        end else begin
            case (state)
                idle, load_1, load_2: begin
                    sck_clear    = 1'b1;
                    nxt_sck_sent = '0;
                    nxt_ss       = 1'b1;
                    nxt_sck      = 1'b0;
                    nxt_sdi      = 1'b0;
                    if (state == idle) begin
                        nxt_state = load_1;
                    end else begin
                        nxt_shift_reg = frame_data;
                        nxt_state     = (state == load_1) ? sent_rst_1 : sent_cmd_2;
                    end
                end
                sent_rst_1, sent_cln_1, sent_cln_2, sent_cmd_2, sent_dig_2,
                sent_cmd_3, sent_dig_3, sent_cmd_4, sent_dig_4: begin
                    nxt_ss = 1'b0;
                    if (sck_fall) begin
                        nxt_sck = 1'b0;
                        if (sck_sent == 4'd8) begin
                            nxt_state    = state_t'(state + 5'd1);
                            nxt_sck_sent = '0;
                        end else begin
                            nxt_sck_sent = sck_sent + 4'd1;
                            nxt_sdi      = tx_bit;
                            if (!is_setup) begin
                                nxt_shift_reg = {shift_reg[46:0], 1'b0};
                            end
                        end
                    end else if (sck_rise && sck_sent != 4'd0) begin
                        nxt_sck = 1'b1;  // First rise only aligns the phase
                    end
                end
                wait_rst_1, wait_cln_1, wait_cln_2, wait_cmd_2, wait_dig_2,
                wait_cmd_3, wait_dig_3, wait_cmd_4, wait_dig_4: begin
                    nxt_sdi = 1'b0;
                    // Keep ss low between a command and its data
                    nxt_ss  = !((state == wait_cln_1) || (state == wait_cmd_2) ||
                                (state == wait_cmd_3) || (state == wait_cmd_4));
                    if (sck_fall) begin
                        if (sck_sent == 4'd15) begin
                            nxt_sck_sent = '0;
                            nxt_state    = state_t'(state + 5'd1);  // wait_dig_4 goes to load_2
                        end else begin
                            nxt_sck_sent = sck_sent + 4'd1;
                        end
                    end
                end
                default: begin
                    nxt_state = idle;
                    sck_clear = 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/ssd_timer_top.sv */
// Timer top level: APB registers, counter, digit encoders, SPI display path.
// tick_div is clocks per second (2 or more), sck_half clocks per SCK half (1 or more).
// No MISO; the display is write-only.
`timescale 1ns/1ps
`default_nettype none

module ssd_timer_top #(
    parameter logic [15:0] tick_div = 16'd50000,
    parameter logic [7:0]  sck_half = 8'd25
) (
    input  logic        clk,
    input  logic        nrst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        ss,
    output logic        sck,
    output logic        sdi
);
    logic run, disp_enable, load, clear, reach_zero;
    ssd_pkg::count_dir_t dir;
    ssd_pkg::timer_value_t load_value, value;
    logic [2:0][3:0] digit_val;
    ssd_pkg::seg_t [2:0] digit_seg;
    logic sck_clear, sck_rise, sck_fall;

    apb_timer_regs u_regs (
        .clk(clk), .nrst(nrst),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .value(value), .reach_zero(reach_zero),
        .run(run), .dir(dir), .disp_enable(disp_enable),
        .load(load), .load_value(load_value), .clear(clear)
    );

    timer_counter #(.tick_div(tick_div)) u_counter (
        .clk(clk), .nrst(nrst), .run(run), .dir(dir),
        .load(load), .load_value(load_value), .clear(clear),
        .value(value), .reach_zero(reach_zero)
    );

    assign digit_val[0] = {1'b0, value.min};
    assign digit_val[1] = {1'b0, value.sec_ten};
    assign digit_val[2] = value.sec_one;

    for (genvar i = 0; i < 3; i++) begin : g_digit
        ssd_digit_encoder u_enc (.digit(digit_val[i]), .seg(digit_seg[i]));
    end

    spi_clock_divider #(.sck_half(sck_half)) u_sck_div (
        .clk(clk), .nrst(nrst), .sck_clear(sck_clear),
        .sck_rise(sck_rise), .sck_fall(sck_fall)
    );

    ssd_spi_master u_master (
        .clk(clk), .nrst(nrst), .enable(disp_enable), .digits(digit_seg),
        .sck_rise(sck_rise), .sck_fall(sck_fall), .sck_clear(sck_clear),
        .ss(ss), .sck(sck), .sdi(sdi)
    );

endmodule

`default_nettype wire

/* verif/clk_gen.sv */
// Testbench clock and reset source.
// 40 ns clock period, nrst held low for the first 10 rising edges.
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk,
    output logic nrst
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        nrst = 1'b0;
        repeat (10) @(posedge clk);
        nrst <= 1'b1;  // Release on a rising edge
    end

endmodule

`default_nettype wire

/* verif/tb_ssd_timer.sv */
// Testbench for the seven-segment timer with an APB host and an SPI byte receiver.
// Runs with tick_div 50 and sck_half 2, so one timer second is 50 clocks.
// Expected bytes and values come from the seg_of and next_value models.
`timescale 1ns/1ps
`default_nettype none

module tb_ssd_timer;
    localparam logic [15:0] tick_div = 16'd50;
    localparam logic [7:0]  sck_half = 8'd2;
    localparam int byte_clks = 2 * sck_half * 26;  // 8 bits, alignment, 16 waits, slack
    localparam int frame_clks = 6 * byte_clks;
    localparam int n_frames = 4;
    localparam int count_clks = 20 * tick_div;
    localparam int watchdog_clks = (n_frames * frame_clks + count_clks) * 2;

    logic clk, nrst;
    logic psel = 1'b0;
    logic penable = 1'b0;
    logic pwrite = 1'b0;
    logic [7:0] paddr = 8'h00;
    logic [31:0] pwdata = 32'h0;
    logic [31:0] prdata;
    logic pready, pslverr, ss, sck, sdi;

    logic [31:0] lfsr_state = 32'h890b_2849;
    logic [7:0] rx_bytes[$];
    logic gap_q[$];  // ss rose before byte i
    logic [7:0] rx_shift = 8'h00;
    int rx_bit_cnt = 0;
    logic sck_d = 1'b0;
    logic ss_d = 1'b1;
    logic ss_rose = 1'b0;

    clk_gen u_clk (.clk(clk), .nrst(nrst));

    ssd_timer_top #(.tick_div(tick_div), .sck_half(sck_half)) UUT (
        .clk(clk), .nrst(nrst),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .ss(ss), .sck(sck), .sdi(sdi)
    );

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        abort_run();
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic ssd_pkg::timer_value_t random_value();
        ssd_pkg::timer_value_t v;
        v.min     = 3'(rand_bits(3));
        v.sec_ten = 3'(rand_bits(3) % 6);
        v.sec_one = 4'(rand_bits(4) % 10);
        return v;
    endfunction

    // Standard gfedcba patterns
    function automatic logic [7:0] seg_of(input logic [3:0] d);
        case (d)
            4'd0: return 8'h3F;
            4'd1: return 8'h06;
            4'd2: return 8'h5B;
            4'd3: return 8'h4F;
            4'd4: return 8'h66;
            4'd5: return 8'h6D;
            4'd6: return 8'h7D;
            4'd7: return 8'h07;
            4'd8: return 8'h7F;
            4'd9: return 8'h6F;
            default: return 8'h00;
        endcase
    endfunction

    // Counts in plain seconds with 480 per wrap
    function automatic ssd_pkg::timer_value_t next_value(input ssd_pkg::timer_value_t v,
                                                         input ssd_pkg::count_dir_t d);
        int secs;
        ssd_pkg::timer_value_t r;
        secs = v.min * 60 + v.sec_ten * 10 + v.sec_one;
        if (d == ssd_pkg::dir_up) begin
            secs = (secs + 1) % 480;
        end else if (secs > 0) begin
            secs = secs - 1;
        end
        r.min     = 3'(secs / 60);
        r.sec_ten = 3'((secs % 60) / 10);
        r.sec_one = 4'(secs % 10);
        return r;
    endfunction

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);  // Write edge
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;  // Mid access phase
        assert (pready && !pslverr) else report_problem("APB read did not complete cleanly");
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic read_value(output ssd_pkg::timer_value_t v);
        logic [31:0] d;
        read_reg(ssd_pkg::addr_value, d);
        check_eq("prdata upper bits", {10'h0, d[31:10]}, 32'h0);
        v = ssd_pkg::timer_value_t'(d[9:0]);
    endtask

    task automatic flush_receiver();
        rx_bytes.delete();
        gap_q.delete();
        rx_bit_cnt = 0;
        ss_rose = 1'b0;
    endtask

    task automatic wait_bytes(input int n);
        int waited;
        waited = 0;
        while (rx_bytes.size() < n) begin
            @(negedge clk);
            waited++;
            if (waited > n * byte_clks * 2) report_problem("SPI bytes did not arrive in time");
        end
    endtask

    // SPI receiver finds edges from the previous clock's samples
    always @(posedge clk) begin
        if (nrst) begin
            if (ss && !ss_d) ss_rose = 1'b1;
            if (sck && !sck_d) begin
                assert (!ss) else report_problem("A data bit was clocked while ss was high");
                if (rx_bit_cnt == 0) begin
                    gap_q.push_back(ss_rose);
                    ss_rose = 1'b0;
                end
                rx_shift = {rx_shift[6:0], sdi};  // MSB first
                rx_bit_cnt++;
                if (rx_bit_cnt == 8) begin
                    rx_bytes.push_back(rx_shift);
                    rx_bit_cnt = 0;
                end
            end
        end
        ss_d  = ss;
        sck_d = sck;
    end

    initial begin
        repeat (watchdog_clks) @(posedge clk);
        report_problem("Watchdog timeout, the run took too long");
    end

    initial begin
        logic [31:0] d;
        ssd_pkg::timer_value_t v, cur, prev, nxt;
        logic [7:0] exp_bytes[$];
        logic exp_high[$];
        int waited;
        int changes;

        @(posedge nrst);
        @(negedge clk);

        // Reset state
        read_reg(ssd_pkg::addr_ctrl, d);
        check_eq("ctrl", d, 32'h0);
        read_reg(ssd_pkg::addr_value, d);
        check_eq("value", d, 32'h0);
        read_reg(ssd_pkg::addr_status, d);
        check_eq("status", d, 32'h0);
        @(negedge clk);
        check_eq("ss", ss, 1'b1);
        check_eq("sck", sck, 1'b0);

        // Load and clear with run off
        write_reg(ssd_pkg::addr_ctrl, 32'h0);
        repeat (8) begin
            v = random_value();
            write_reg(ssd_pkg::addr_load, {22'h0, v});
            read_value(cur);
            check_eq("value", cur, v);
        end
        v = {3'd5, 3'd4, 4'd1};
        write_reg(ssd_pkg::addr_load, {22'h0, v});
        read_value(cur);
        check_eq("value", cur, v);
        write_reg(ssd_pkg::addr_ctrl, 32'h8);
        read_value(cur);
        check_eq("value", cur, 32'h0);
        read_reg(ssd_pkg::addr_ctrl, d);
        check_eq("ctrl", d, 32'h0);  // Clear bit reads back 0

        // Display frames
        v = random_value();
        write_reg(ssd_pkg::addr_load, {22'h0, v});
        @(negedge clk);
        flush_receiver();
        write_reg(ssd_pkg::addr_ctrl, 32'h4);
        exp_bytes.push_back(ssd_pkg::cmd_reset);
        exp_bytes.push_back(ssd_pkg::cmd_decimal);
        exp_bytes.push_back(ssd_pkg::dp_colon);
        exp_high.push_back(1'b1);
        exp_high.push_back(1'b0);
        exp_high.push_back(1'b1);
        repeat (2) begin
            exp_bytes.push_back(ssd_pkg::cmd_digit2);
            exp_bytes.push_back(seg_of({1'b0, v.min}));
            exp_bytes.push_back(ssd_pkg::cmd_digit3);
            exp_bytes.push_back(seg_of({1'b0, v.sec_ten}));
            exp_bytes.push_back(ssd_pkg::cmd_digit4);
            exp_bytes.push_back(seg_of(v.sec_one));
            repeat (3) begin
                exp_high.push_back(1'b0);  // Command then data
                exp_high.push_back(1'b1);
            end
        end
        wait_bytes(exp_bytes.size());
        for (int i = 0; i < exp_bytes.size(); i++) begin
            check_eq("spi byte", rx_bytes[i], exp_bytes[i]);
            if (i > 0) check_eq("ss high after byte", gap_q[i], exp_high[i - 1]);
        end

        // Display off in the middle of a byte
        waited = 0;
        while (rx_bit_cnt != 3) begin
            @(negedge clk);
            waited++;
            if (waited > 2 * byte_clks) report_problem("No SPI byte started after the frames");
        end
        write_reg(ssd_pkg::addr_ctrl, 32'h0);
        @(posedge clk);
        repeat (4 * byte_clks) begin
            @(negedge clk);
            check_eq("ss", ss, 1'b1);
            check_eq("sck", sck, 1'b0);
        end
        flush_receiver();

        // Up count
        v = random_value();
        write_reg(ssd_pkg::addr_load, {22'h0, v});
        write_reg(ssd_pkg::addr_ctrl, 32'h1);
        read_value(prev);
        changes = 0;
        repeat (40) begin
            read_value(cur);
            nxt = next_value(prev, ssd_pkg::dir_up);
            assert (cur == prev || cur == nxt) else begin
                $display("Error: value is 0x%h, expected 0x%h or 0x%h", cur, prev, nxt);
                abort_run();
            end
            if (cur != prev) changes++;
            prev = cur;
        end
        assert (changes > 0) else report_problem("Timer never advanced while counting up");
        v = {3'd7, 3'd5, 4'd9};
        write_reg(ssd_pkg::addr_load, {22'h0, v});
        waited = 0;
        do begin
            read_value(cur);
            waited++;
            if (waited > 2 * tick_div) report_problem("Timer stuck at 7:59");
        end while (cur == v);
        check_eq("value", cur, next_value(v, ssd_pkg::dir_up));

        // Down count to zero and sticky done
        write_reg(ssd_pkg::addr_ctrl, 32'h2);
        write_reg(ssd_pkg::addr_load, {22'h0, 3'd0, 3'd0, 4'd3});
        write_reg(ssd_pkg::addr_ctrl, 32'h3);
        read_reg(ssd_pkg::addr_status, d);
        check_eq("status", d, 32'h0);
        read_value(prev);
        waited = 0;
        d = 32'h0;
        while (d[0] == 1'b0) begin
            read_reg(ssd_pkg::addr_status, d);
            read_value(cur);
            nxt = next_value(prev, ssd_pkg::dir_down);
            assert (cur == prev || cur == nxt) else begin
                $display("Error: value is 0x%h, expected 0x%h or 0x%h", cur, prev, nxt);
                abort_run();
            end
            prev = cur;
            waited++;
            if (waited > 4 * tick_div) report_problem("Done never set on the down count");
        end
        read_value(cur);
        check_eq("value", cur, 32'h0);
        repeat (2 * tick_div) @(posedge clk);
        read_value(cur);
        check_eq("value", cur, 32'h0);
        read_reg(ssd_pkg::addr_status, d);
        check_eq("status", d, 32'h1);
        write_reg(ssd_pkg::addr_ctrl, 32'h0);
        read_reg(ssd_pkg::addr_status, d);
        check_eq("status", d, 32'h0);

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
common/ssd_pkg.sv
design/apb_timer_regs.sv
design/timer_counter.sv
design/ssd_digit_encoder.sv
spi/spi_clock_divider.sv
spi/ssd_spi_master.sv
design/ssd_timer_top.sv
verif/clk_gen.sv
verif/tb_ssd_timer.sv

/* Bender.yml */
package:
  name: ssd_timer

sources:
  - common/ssd_pkg.sv
  - design/apb_timer_regs.sv
  - design/timer_counter.sv
  - design/ssd_digit_encoder.sv
  - spi/spi_clock_divider.sv
  - spi/ssd_spi_master.sv
  - design/ssd_timer_top.sv
  - target: simulation
    files:
      - verif/clk_gen.sv
      - verif/tb_ssd_timer.sv
